// ==== include/jump_predictor_cfg.svh ====
`ifndef JUMP_PREDICTOR_CFG_SVH
`define JUMP_PREDICTOR_CFG_SVH

// number of prediction table entries, a power of two, at most 4096
`define JP_TABLE_SIZE 4096

// table index width: pc[28] joined with pc[12:2]
`define JP_INDEX_W 12

// first fetch address after reset
`define JP_RESET_PC 32'h1000_0000

`endif

// ==== hw/jump_predictor_pkg.sv ====
package jump_predictor_pkg;

    // instruction classes seen by the fetch-side predictor
    // jal, jalr and branch are the ones that can be predicted
    typedef enum logic [3:0] {
        ir_jal    = 4'd0,
        ir_jalr   = 4'd1,
        ir_branch = 4'd2,
        ir_load   = 4'd3,
        ir_store  = 4'd4,
        ir_op     = 4'd5,
        ir_op_imm = 4'd6,
        ir_lui    = 4'd7,
        ir_auipc  = 4'd8,
        ir_system = 4'd9,
        ir_other  = 4'd10
    } ir_type_e;

    // table clear sequencer states
    // clr_idle is the settle cycle between a flush and its sweep
    typedef enum logic [1:0] {
        clr_idle  = 2'd0,
        clr_sweep = 2'd1,
        clr_ready = 2'd2
    } clear_state_e;

endpackage

// ==== hw/ir_predecoder.sv ====
`timescale 1ns/1ps

module ir_predecoder (
    input  logic [31:0]                  instr,
    output jump_predictor_pkg::ir_type_e ir_type
);

    import jump_predictor_pkg::*;

    // rv32 base opcodes, low two bits are always 2'b11
    localparam logic [4:0] OPC_LOAD   = 5'b00000;
    localparam logic [4:0] OPC_OP_IMM = 5'b00100;
    localparam logic [4:0] OPC_AUIPC  = 5'b00101;
    localparam logic [4:0] OPC_STORE  = 5'b01000;
    localparam logic [4:0] OPC_OP     = 5'b01100;
    localparam logic [4:0] OPC_LUI    = 5'b01101;
    localparam logic [4:0] OPC_BRANCH = 5'b11000;
    localparam logic [4:0] OPC_JALR   = 5'b11001;
    localparam logic [4:0] OPC_JAL    = 5'b11011;
    localparam logic [4:0] OPC_SYSTEM = 5'b11100;

    // a word without 2'b11 in bits [1:0] is not a 32-bit instruction
    logic is_32bit;

    assign is_32bit = (instr[1:0] == 2'b11);

    always_comb begin
        // anything unknown falls through to ir_other
        ir_type = ir_other;
        if (is_32bit) begin
            case (instr[6:2])
                OPC_JAL:    ir_type = ir_jal;
                OPC_JALR:   ir_type = ir_jalr;
                OPC_BRANCH: ir_type = ir_branch;
                OPC_LOAD:   ir_type = ir_load;
                OPC_STORE:  ir_type = ir_store;
                OPC_OP:     ir_type = ir_op;
                OPC_OP_IMM: ir_type = ir_op_imm;
                OPC_LUI:    ir_type = ir_lui;
                OPC_AUIPC:  ir_type = ir_auipc;
                OPC_SYSTEM: ir_type = ir_system;
                default:    ir_type = ir_other;
            endcase
        end
    end

endmodule

// ==== hw/u_jump_predictor.sv ====
`timescale 1ns/1ps
`include "jump_predictor_cfg.svh"

// one-bit jump predictor table
// read is combinational from the fetch pc, writes land on the rising edge
module u_jump_predictor #(
    parameter int TABLE_SIZE = `JP_TABLE_SIZE
) (
    input  logic                          clk,

    // fetch side, used for the read
    input  logic [31:0]                   pc_in_if,
    input  logic [31:0]                   pc4_in_if,
    input  jump_predictor_pkg::ir_type_e  ir_type_in_if,

    // execute side, used for the update
    input  jump_predictor_pkg::ir_type_e  ir_type_in_ex,
    input  logic                          ex_valid,
    input  logic [31:0]                   pc_in_ex,
    input  logic [31:0]                   jump_addr_if_taken,
    input  logic                          is_prediction_wrong,
    input  logic                          jump_result,

    // clear sweep
    input  logic                          clear_active,
    input  logic [`JP_INDEX_W-1:0]        clear_index,

    // prediction back to fetch
    output logic                          u_jump,
    output logic [31:0]                   addr_prediction
);

    import jump_predictor_pkg::*;

    localparam int IDX_W = $clog2(TABLE_SIZE);

    // valid: target holds a real address
    // state: 1 means take the jump
    typedef struct packed {
        logic        valid;
        logic        state;
        logic [31:0] target;
    } entry_t;

    entry_t entries [TABLE_SIZE];

    logic             is_jump_if;
    logic             is_jump_ex;
    logic [IDX_W-1:0] rd_idx;
    logic [IDX_W-1:0] wr_idx;
    logic             update_entry;
    entry_t           rd_entry;

    // only control transfers use the table
    function automatic logic is_jump_type(input ir_type_e t);
        return (t == ir_jal) || (t == ir_jalr) || (t == ir_branch);
    endfunction

    // user/machine bit on top, word address bits below
    function automatic logic [IDX_W-1:0] entry_index(input logic [31:0] pc);
        return {pc[28], pc[IDX_W:2]};
    endfunction

    assign is_jump_if = is_jump_type(ir_type_in_if);
    assign is_jump_ex = is_jump_type(ir_type_in_ex);
    assign rd_idx     = entry_index(pc_in_if);
    assign wr_idx     = entry_index(pc_in_ex);

    // execute reports are dropped while the table is being cleared
    assign update_entry = ex_valid && is_jump_ex && is_prediction_wrong && !clear_active;

    // asynchronous read
    assign rd_entry = entries[rd_idx];

    always_comb begin
        // default is the sequential next address
        u_jump          = 1'b0;
        addr_prediction = pc4_in_if;
        // predict only a valid, taken entry for a jump type
        if (is_jump_if && rd_entry.valid && rd_entry.state && !clear_active) begin
            u_jump          = 1'b1;
            addr_prediction = rd_entry.target;
        end
    end

    // clear writes win over updates
    always_ff @(posedge clk) begin
        if (clear_active) begin
            entries[clear_index[IDX_W-1:0]] <= '0;
        end else if (update_entry) begin
            entries[wr_idx] <= '{valid: 1'b1, state: jump_result, target: jump_addr_if_taken};
        end
    end

endmodule

// ==== hw/table_clear_counter.sv ====
`timescale 1ns/1ps
`include "jump_predictor_cfg.svh"

module table_clear_counter #(
    parameter int TABLE_SIZE = `JP_TABLE_SIZE
) (
    input  logic                   clk,
    input  logic                   reset,
    input  logic                   enable,
    output logic [`JP_INDEX_W-1:0] index,
    output logic                   last
);

    // final index of the sweep
    localparam logic [`JP_INDEX_W-1:0] LAST_INDEX = `JP_INDEX_W'(TABLE_SIZE - 1);

    logic at_end;

    assign at_end = (index == LAST_INDEX);

    // flags the final entry only while sweeping
    assign last = enable && at_end;

    // wraps to zero so the next sweep starts from entry 0
    always_ff @(posedge clk) begin
        if (reset) begin
            index <= '0;
        end else if (enable) begin
            index <= at_end ? '0 : index + 1'b1;
        end
    end

endmodule

// ==== hw/predictor_clear_fsm.sv ====
`timescale 1ns/1ps

// sequences the table clear after reset and on flush
module predictor_clear_fsm (
    input  logic                             clk,
    input  logic                             reset,
    input  logic                             flush,
    input  logic                             sweep_last,
    output logic                             clear_active,
    output logic                             ready,
    output jump_predictor_pkg::clear_state_e state
);

    import jump_predictor_pkg::*;

    clear_state_e next_state;

    always_comb begin
        next_state = state;
        case (state)
            // last entry written, table is clean
            clr_sweep: begin
                if (sweep_last) begin
                    next_state = clr_ready;
                end
            end
            // flush only counts once the table is in use
            clr_ready: begin
                if (flush) begin
                    next_state = clr_idle;
                end
            end
            // one settle cycle, counter sits at zero
            clr_idle: next_state = clr_sweep;
            default:  next_state = clr_sweep;
        endcase
    end

    // reset goes straight into a sweep
    always_ff @(posedge clk) begin
        if (reset) begin
            state <= clr_sweep;
        end else begin
            state <= next_state;
        end
    end

    // counter and table writes run only in the sweep
    assign clear_active = (state == clr_sweep);
    assign ready        = (state == clr_ready);

endmodule

// ==== hw/fetch_pc_unit.sv ====
`timescale 1ns/1ps
`include "jump_predictor_cfg.svh"

module fetch_pc_unit (
    input  logic        clk,
    input  logic        reset,
    input  logic        ready,
    input  logic        stall,
    input  logic        ex_valid,
    input  logic        is_prediction_wrong,
    input  logic        jump_result,
    input  logic [31:0] pc_in_ex,
    input  logic [31:0] jump_addr_if_taken,
    input  logic [31:0] addr_prediction,
    output logic [31:0] pc_if,
    output logic [31:0] pc4
);

    logic        redirect;
    logic [31:0] redirect_pc;

    // sequential address for the predictor's fall-through
    assign pc4 = pc_if + 32'd4;

    // execute found a wrong prediction
    assign redirect = ex_valid && is_prediction_wrong;

    // correct next address from the resolved jump
    assign redirect_pc = jump_result ? jump_addr_if_taken : pc_in_ex + 32'd4;

    always_ff @(posedge clk) begin
        if (reset) begin
            pc_if <= `JP_RESET_PC;
        end else if (redirect) begin
            // redirect beats stall and the clear sweep
            pc_if <= redirect_pc;
        end else if (ready && !stall) begin
            pc_if <= addr_prediction;
        end
        // otherwise hold
    end

endmodule

// ==== hw/jump_predict_unit.sv ====
`timescale 1ns/1ps
`include "jump_predictor_cfg.svh"

module jump_predict_unit (
    input  logic                         clk,
    input  logic                         reset,
    input  logic [31:0]                  instr_if,
    input  logic                         stall,
    input  logic                         flush,
    input  logic                         ex_valid,
    input  logic [31:0]                  pc_in_ex,
    input  jump_predictor_pkg::ir_type_e ir_type_in_ex,
    input  logic [31:0]                  jump_addr_if_taken,
    input  logic                         jump_result,
    input  logic                         is_prediction_wrong,
    output logic [31:0]                  pc_if,
    output logic                         u_jump,
    output logic [31:0]                  addr_prediction,
    output logic                         ready
);

    import jump_predictor_pkg::*;

    ir_type_e               ir_type_in_if;
    logic [31:0]            pc4;
    logic                   clear_active;
    logic [`JP_INDEX_W-1:0] clear_index;
    logic                   clear_last;

    ir_predecoder u_predecoder (
        .instr   (instr_if),
        .ir_type (ir_type_in_if)
    );

    u_jump_predictor #(
        .TABLE_SIZE (`JP_TABLE_SIZE)
    ) u_predictor (
        .clk                 (clk),
        .pc_in_if            (pc_if),
        .pc4_in_if           (pc4),
        .ir_type_in_if       (ir_type_in_if),
        .ir_type_in_ex       (ir_type_in_ex),
        .ex_valid            (ex_valid),
        .pc_in_ex            (pc_in_ex),
        .jump_addr_if_taken  (jump_addr_if_taken),
        .is_prediction_wrong (is_prediction_wrong),
        .jump_result         (jump_result),
        .clear_active        (clear_active),
        .clear_index         (clear_index),
        .u_jump              (u_jump),
        .addr_prediction     (addr_prediction)
    );

    table_clear_counter #(
        .TABLE_SIZE (`JP_TABLE_SIZE)
    ) u_clear_counter (
        .clk    (clk),
        .reset  (reset),
        .enable (clear_active),
        .index  (clear_index),
        .last   (clear_last)
    );

    predictor_clear_fsm u_clear_fsm (
        .clk          (clk),
        .reset        (reset),
        .flush        (flush),
        .sweep_last   (clear_last),
        .clear_active (clear_active),
        .ready        (ready),
        .state        ()
    );

    fetch_pc_unit u_pc_unit (
        .clk                 (clk),
        .reset               (reset),
        .ready               (ready),
        .stall               (stall),
        .ex_valid            (ex_valid),
        .is_prediction_wrong (is_prediction_wrong),
        .jump_result         (jump_result),
        .pc_in_ex            (pc_in_ex),
        .jump_addr_if_taken  (jump_addr_if_taken),
        .addr_prediction     (addr_prediction),
        .pc_if               (pc_if),
        .pc4                 (pc4)
    );

endmodule

// ==== tests/tb_clock_gen.sv ====
`timescale 1ns/1ps

// free-running testbench clock
module tb_clock_gen #(
    parameter int HALF_PERIOD_NS = 20
) (
    output logic clk
);

    // 40 ns period with the default half period
    initial begin
        clk = 1'b0;
        forever begin
            #(HALF_PERIOD_NS) clk = ~clk;
        end
    end

endmodule

// ==== tests/jump_predict_unit_assertions.sv ====
`timescale 1ns/1ps
`include "jump_predictor_cfg.svh"

module jump_predict_unit_assertions (
    input logic        clk,
    input logic        reset,
    input logic        stall,
    input logic        ex_valid,
    input logic        is_prediction_wrong,
    input logic        u_jump,
    input logic        ready,
    input logic [31:0] pc_if
);

    // cycles with ready low since reset or since ready last fell
    int unsigned low_cycles;

    always_ff @(posedge clk) begin
        if (reset || ready) begin
            low_cycles <= 0;
        end else if (low_cycles < 32'hffff_0000) begin
            low_cycles <= low_cycles + 1;
        end
    end

    // no prediction while the table is being cleared
    jump_needs_ready: assert property (@(posedge clk) disable iff (reset) u_jump |-> ready)
        else $error("u_jump high while ready is low");

    // a full sweep passes before ready comes back
    sweep_length: assert property (@(posedge clk) disable iff (reset)
        $rose(ready) |-> low_cycles >= `JP_TABLE_SIZE)
        else $error("ready rose after only %0d low cycles", low_cycles);

    // stall holds the fetch pc unless execute redirects
    stall_holds_pc: assert property (@(posedge clk) disable iff (reset)
        (stall && !(ex_valid && is_prediction_wrong)) |=> $stable(pc_if))
        else $error("pc_if moved during a stall");

endmodule

bind jump_predict_unit jump_predict_unit_assertions u_assertions (
    .clk                 (clk),
    .reset               (reset),
    .stall               (stall),
    .ex_valid            (ex_valid),
    .is_prediction_wrong (is_prediction_wrong),
    .u_jump              (u_jump),
    .ready               (ready),
    .pc_if               (pc_if)
);

// ==== tests/jump_predict_unit_tb.sv ====
`timescale 1ns/1ps
`include "jump_predictor_cfg.svh"

module jump_predict_unit_tb;

    import jump_predictor_pkg::*;

    // sample rv32 words, one per predecoder class
    localparam logic [31:0] INSTR_JAL  = 32'h0000_006f;
    localparam logic [31:0] INSTR_ADDI = 32'h0000_0013;

    logic        clk;
    logic        reset;
    logic [31:0] instr_if;
    logic        stall;
    logic        flush;
    logic        ex_valid;
    logic [31:0] pc_in_ex;
    ir_type_e    ir_type_in_ex;
    logic [31:0] jump_addr_if_taken;
    logic        jump_result;
    logic        is_prediction_wrong;
    logic [31:0] pc_if;
    logic        u_jump;
    logic [31:0] addr_prediction;
    logic        ready;

    // reference copy of the prediction table
    logic        model_valid  [`JP_TABLE_SIZE];
    logic        model_state  [`JP_TABLE_SIZE];
    logic [31:0] model_target [`JP_TABLE_SIZE];
    logic [31:0] trained_pcs [$];
    logic [31:0] pc_a;
    logic [31:0] tgt_a;
    int          errors;

    tb_clock_gen u_clk (.clk(clk));

    jump_predict_unit u_dut (
        .clk(clk), .reset(reset), .instr_if(instr_if), .stall(stall), .flush(flush),
        .ex_valid(ex_valid), .pc_in_ex(pc_in_ex), .ir_type_in_ex(ir_type_in_ex),
        .jump_addr_if_taken(jump_addr_if_taken), .jump_result(jump_result),
        .is_prediction_wrong(is_prediction_wrong), .pc_if(pc_if), .u_jump(u_jump),
        .addr_prediction(addr_prediction), .ready(ready)
    );

    task automatic stop_run(input string why);
        errors++;
        if (why != "") $display("%s", why);
        $display("FAIL: see errors above");
        $fatal(1, "stopped at first error");
    endtask

    task automatic check_addr(input string name, input logic [31:0] act, input logic [31:0] exp);
        if (act !== exp) begin
            $display("** Error at %0t: %s = 0x%08h, expected 0x%08h", $time, name, act, exp);
            stop_run("");
        end
    endtask

    task automatic check_bit(input string name, input logic act, input logic exp);
        if (act !== exp) begin
            $display("** Error at %0t: %s = %b, expected %b", $time, name, act, exp);
            stop_run("");
        end
    endtask

    task automatic check_type(input string name, input ir_type_e act, input ir_type_e exp);
        if (act !== exp) begin
            $display("** Error at %0t: %s = %s, expected %s", $time, name, act.name(),
                     exp.name());
            stop_run("");
        end
    endtask

    // pc[28] on top of the word address bits
    function automatic int unsigned table_slot(input logic [31:0] pc);
        return {pc[28], pc[12:2]};
    endfunction

    function automatic logic is_control(input ir_type_e t);
        return t == ir_jal || t == ir_jalr || t == ir_branch;
    endfunction

    function automatic logic [31:0] random_pc();
        return $urandom & 32'hffff_fffc;
    endfunction

    task automatic clear_model();
        for (int i = 0; i < `JP_TABLE_SIZE; i++) begin
            model_valid[i] = 1'b0;
            model_state[i] = 1'b0;
        end
    endtask

    task automatic idle_execute();
        ex_valid            <= 1'b0;
        is_prediction_wrong <= 1'b0;
        jump_result         <= 1'b0;
        ir_type_in_ex       <= ir_other;
    endtask

    // one execute report, held for a single edge
    task automatic report(input logic [31:0] pc, input ir_type_e t, input logic taken,
                          input logic [31:0] tgt, input logic wrong, input logic learn);
        int unsigned slot;
        @(posedge clk);
        ex_valid            <= 1'b1;
        pc_in_ex            <= pc;
        ir_type_in_ex       <= t;
        jump_result         <= taken;
        jump_addr_if_taken  <= tgt;
        is_prediction_wrong <= wrong;
        @(posedge clk);
        idle_execute();
        slot = table_slot(pc);
        if (learn && wrong && is_control(t)) begin
            model_valid[slot]  = 1'b1;
            model_state[slot]  = taken;
            model_target[slot] = tgt;
        end
    endtask

    // steer fetch to pc under stall, then check the prediction there
    task automatic expect_prediction(input logic [31:0] pc, input logic [31:0] instr,
                                     input ir_type_e exp_type);
        int unsigned slot;
        logic        exp_jump;
        slot = table_slot(pc);
        exp_jump = is_control(exp_type) && model_valid[slot] && model_state[slot];
        @(posedge clk);
        instr_if            <= instr;
        stall               <= 1'b1;
        ex_valid            <= 1'b1;
        ir_type_in_ex       <= ir_other;
        jump_result         <= 1'b1;
        jump_addr_if_taken  <= pc;
        is_prediction_wrong <= 1'b1;
        @(posedge clk);
        idle_execute();
        @(negedge clk);
        check_addr("pc_if", pc_if, pc);
        check_type("ir_type_in_if", u_dut.ir_type_in_if, exp_type);
        check_bit("u_jump", u_jump, exp_jump);
        check_addr("addr_prediction", addr_prediction, exp_jump ? model_target[slot] : pc + 4);
    endtask

    task automatic wait_for_ready(input int limit);
        logic seen;
        seen = 1'b0;
        for (int i = 0; i < limit && !seen; i++) begin
            @(negedge clk);
            check_bit("u_jump", u_jump, 1'b0);
            seen = ready;
        end
        if (!seen) stop_run($sformatf("timeout: ready still low after %0d cycles", limit));
    endtask

    task automatic test_reset_sweep();
        repeat (10) @(posedge clk);
        reset    <= 1'b0;
        instr_if <= INSTR_JAL;
        @(negedge clk);
        check_addr("pc_if", pc_if, `JP_RESET_PC);
        check_bit("ready", ready, 1'b0);
        wait_for_ready(`JP_TABLE_SIZE + 2);
    endtask

    task automatic test_untrained();
        logic [31:0] words [11];
        ir_type_e    types [11];
        logic [31:0] start_pc;
        words = '{32'h6f, 32'h67, 32'h63, 32'h03, 32'h23, 32'h33, 32'h13, 32'h37, 32'h17,
                  32'h73, 32'h01};
        types = '{ir_jal, ir_jalr, ir_branch, ir_load, ir_store, ir_op, ir_op_imm, ir_lui,
                  ir_auipc, ir_system, ir_other};
        foreach (words[i]) expect_prediction(random_pc(), words[i], types[i]);
        // free-running sequential fetch from a known pc
        start_pc = random_pc();
        expect_prediction(start_pc, INSTR_ADDI, ir_op_imm);
        @(posedge clk);
        stall <= 1'b0;
        @(negedge clk);
        check_addr("pc_if", pc_if, start_pc);
        for (int i = 1; i <= 8; i++) begin
            @(negedge clk);
            check_addr("pc_if", pc_if, start_pc + 32'(4 * i));
        end
    endtask

    task automatic test_train_taken();
        pc_a  = random_pc();
        tgt_a = random_pc();
        report(pc_a, ir_jal, 1'b1, tgt_a, 1'b1, 1'b1);
        trained_pcs.push_back(pc_a);
        expect_prediction(pc_a, INSTR_JAL, ir_jal);
        check_bit("u_jump", u_jump, 1'b1);
        // release the stall so fetch follows the prediction
        @(posedge clk);
        stall <= 1'b0;
        @(posedge clk);
        stall <= 1'b1;
        @(negedge clk);
        check_addr("pc_if", pc_if, tgt_a);
        expect_prediction(pc_a, INSTR_ADDI, ir_op_imm);
    endtask

    task automatic test_update_rules();
        logic [31:0] pc_b;
        logic [31:0] pc_c;
        logic [31:0] tgt_b;
        report(pc_a, ir_jal, 1'b0, random_pc(), 1'b1, 1'b1);
        expect_prediction(pc_a, INSTR_JAL, ir_jal);
        report(pc_a, ir_branch, 1'b1, tgt_a, 1'b1, 1'b1);
        // a correct prediction report leaves the entry alone
        report(pc_a, ir_jal, 1'b0, random_pc(), 1'b0, 1'b1);
        expect_prediction(pc_a, INSTR_JAL, ir_jal);
        check_bit("u_jump", u_jump, 1'b1);
        // user/machine bit selects a separate entry
        pc_b  = pc_a ^ 32'h1000_0000;
        tgt_b = random_pc();
        report(pc_b, ir_jalr, 1'b1, tgt_b, 1'b1, 1'b1);
        trained_pcs.push_back(pc_b);
        expect_prediction(pc_a, INSTR_JAL, ir_jal);
        expect_prediction(pc_b, 32'h0000_0063, ir_branch);
        // bits above 12 other than 28 alias
        pc_c = pc_a ^ 32'h0010_0000;
        expect_prediction(pc_c, 32'h0000_0067, ir_jalr);
        check_addr("addr_prediction", addr_prediction, tgt_a);
        trained_pcs.push_back(pc_c);
    endtask

    task automatic test_stall();
        logic [31:0] pc_x;
        logic [31:0] pc_y;
        pc_x = random_pc();
        expect_prediction(pc_x, INSTR_ADDI, ir_op_imm);
        repeat (5) begin
            @(negedge clk);
            check_addr("pc_if", pc_if, pc_x);
        end
        // redirect wins over the stall
        pc_y = random_pc();
        @(posedge clk);
        ex_valid            <= 1'b1;
        ir_type_in_ex       <= ir_other;
        jump_result         <= 1'b0;
        pc_in_ex            <= pc_y - 4;
        is_prediction_wrong <= 1'b1;
        @(posedge clk);
        idle_execute();
        repeat (3) begin
            @(negedge clk);
            check_addr("pc_if", pc_if, pc_y);
        end
        @(posedge clk);
        stall <= 1'b0;
        @(posedge clk);
        stall <= 1'b1;
        @(negedge clk);
        check_addr("pc_if", pc_if, pc_y + 4);
    endtask

    task automatic test_flush();
        logic [31:0] pc_hi;
        logic [31:0] pc_lo;
        // pc_hi lands in the last entry swept, pc_lo in the first
        pc_hi = random_pc() | 32'h1000_1ffc;
        pc_lo = random_pc() & 32'hefff_e003;
        report(pc_hi, ir_jal, 1'b1, tgt_a, 1'b1, 1'b1);
        trained_pcs.push_back(pc_hi);
        expect_prediction(pc_hi, INSTR_JAL, ir_jal);
        check_bit("u_jump", u_jump, 1'b1);
        @(posedge clk);
        stall    <= 1'b0;
        flush    <= 1'b1;
        instr_if <= INSTR_ADDI;
        @(posedge clk);
        flush <= 1'b0;
        @(negedge clk);
        check_bit("ready", ready, 1'b0);
        clear_model();
        repeat (50) @(posedge clk);
        instr_if <= INSTR_JAL;
        // dropped by the DUT, so not learned by the model
        // its redirect parks fetch on pc_hi, whose entry is not yet swept
        report(pc_lo, ir_jal, 1'b1, pc_hi, 1'b1, 1'b0);
        wait_for_ready(`JP_TABLE_SIZE + 2);
        foreach (trained_pcs[i]) expect_prediction(trained_pcs[i], INSTR_JAL, ir_jal);
        expect_prediction(pc_lo, INSTR_JAL, ir_jal);
    endtask

    initial begin
        void'($urandom(27));
        errors              = 0;
        reset               = 1'b1;
        instr_if            = INSTR_ADDI;
        stall               = 1'b0;
        flush               = 1'b0;
        ex_valid            = 1'b0;
        pc_in_ex            = '0;
        ir_type_in_ex       = ir_other;
        jump_addr_if_taken  = '0;
        jump_result         = 1'b0;
        is_prediction_wrong = 1'b0;
        clear_model();
        test_reset_sweep();
        test_untrained();
        test_train_taken();
        test_update_rules();
        test_stall();
        test_flush();
        if (errors == 0) begin
            $display("PASS: all tests");
            $finish;
        end else begin
            $display("FAIL: see errors above");
            $fatal(1, "errors found");
        end
    end

endmodule

// ==== jump_predict_unit.f ====
+incdir+include
hw/jump_predictor_pkg.sv
hw/ir_predecoder.sv
hw/u_jump_predictor.sv
hw/table_clear_counter.sv
hw/predictor_clear_fsm.sv
hw/fetch_pc_unit.sv
hw/jump_predict_unit.sv
tests/tb_clock_gen.sv
tests/jump_predict_unit_assertions.sv
tests/jump_predict_unit_tb.sv

// ==== run_sim.sh ====
#!/bin/sh
# build and run the jump predict unit testbench with Verilator

cd "$(dirname "$0")" || exit 1

LOG=sim.log
SIM=jump_predict_unit_sim

verilator --binary --timing --assert -sv \
    -f jump_predict_unit.f \
    --top-module jump_predict_unit_tb \
    -Mdir obj_dir -o "$SIM"
if [ $? -ne 0 ]; then
    echo "verilator build failed"
    exit 1
fi

./obj_dir/"$SIM" > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi

if grep -q "^PASS: all tests$" "$LOG"; then
    exit 0
fi
echo "pass message not found in $LOG"
exit 1
